// ==== dv/tb_cga_model.svh ====
// Gate array reference model
`ifndef TB_CGA_MODEL_SVH
`define TB_CGA_MODEL_SVH

// Registered inputs
cs_word_t    m_uw;
logic [15:0] m_cd;
logic        m_etrap;
int_lines_t  m_lines;
// ALU state
logic [15:0] m_wreg;
logic        m_acond;
// Sequencer state
cs_addr_t    m_csa;
cs_addr_t    m_ret;
logic [7:0]  m_cnt;
// Interrupt unit state
logic        m_ioni;
logic        m_poni;
logic        m_intrq;
int_level_t  m_level;
// Expected pins
logic [15:0] m_fidb;
int_level_t  m_pil;
logic        m_intrq_n;
logic        m_ioni_q;
logic        m_poni_q;
logic        m_trap_n;
// Scenario hit counts
int          n_trap;
int          n_vect;
int          n_ret;
int          n_loop;

// Result in bits 15:0, carry in bit 16
function automatic logic [16:0] alu_eval(input cs_word_t w, input logic [15:0] a,
                                         input logic [15:0] wr);
   logic [15:0] b;
   logic [16:0] diff;
   logic [16:0] res;
   logic        ci;
   b    = w.rbsel[0] ? wr : w.lit.data;
   ci   = w.cinsel[0];
   diff = {1'b0, a} - {1'b0, b} - {16'h0000, ~ci};
   case (w.alui[2:0])
      OP_ADD:    res = {1'b0, a} + {1'b0, b} + {16'h0000, ci};
      // Carry out is the inverted borrow
      OP_SUB:    res = {~diff[16], diff[15:0]};
      OP_AND:    res = {1'b0, a & b};
      OP_OR:     res = {1'b0, a | b};
      OP_XOR:    res = {1'b0, a ^ b};
      OP_PASS_A: res = {1'b0, a};
      OP_PASS_B: res = {1'b0, b};
      default:   res = {1'b0, a} + 17'd1;
   endcase
   return res;
endfunction

// 15 over 13 over 12 over 11 over 10
function automatic int_level_t highest_level(input int_lines_t p);
   int_level_t lvl;
   lvl = 4'd0;
   if (p.l10) lvl = 4'd10;
   if (p.l11) lvl = 4'd11;
   if (p.l12) lvl = 4'd12;
   if (p.l13) lvl = 4'd13;
   if (p.l15) lvl = 4'd15;
   return lvl;
endfunction

// One clock edge with the inputs the DUT samples at that edge
task automatic model_step(input logic r, input logic [63:0] bits, input logic [15:0] d,
                          input logic trap_in_n, input int_lines_t ln);
   logic [16:0] res;
   logic        vec;
   logic [4:0]  c;
   cs_addr_t    inc;
   cs_addr_t    nxt;
   int_lines_t  pend;
   if (r) begin
      m_uw      = '0;
      m_etrap   = 1'b0;
      m_lines   = '0;
      m_wreg    = 16'h0000;
      m_acond   = 1'b0;
      m_csa     = RESET_ADDR;
      m_ret     = RESET_ADDR;
      m_cnt     = 8'h00;
      m_ioni    = 1'b0;
      m_poni    = 1'b0;
      m_intrq   = 1'b0;
      m_level   = 4'd0;
      m_fidb    = 16'h0000;
      m_pil     = 4'd0;
      m_intrq_n = 1'b1;
      m_ioni_q  = 1'b0;
      m_poni_q  = 1'b0;
      m_trap_n  = 1'b1;
   end else begin
      res  = alu_eval(m_uw, m_cd, m_wreg);
      vec  = !m_etrap && m_uw.vect && m_intrq;
      // Command field ignored under trap or vector
      c    = (m_etrap || vec) ? 5'(CMD_NEXT) : m_uw.comm;
      inc  = m_csa + 13'd1;
      pend = m_ioni ? m_lines : '0;
      // Pins from the state before this edge
      m_fidb    = res[15:0];
      m_pil     = m_level;
      m_intrq_n = !m_intrq;
      m_ioni_q  = m_ioni;
      m_poni_q  = m_poni;
      m_trap_n  = !m_etrap;
      nxt = inc;
      if (m_etrap) begin
         nxt    = TRAP_ADDR;
         m_ret  = inc;
         n_trap = n_trap + 1;
      end else if (vec) begin
         nxt    = VECT_BASE + 13'(m_level) * 13'd4;
         n_vect = n_vect + 1;
      end else begin
         case (c)
            CMD_JUMP:   nxt = m_uw.lit.jump.target;
            CMD_CJUMP:  nxt = m_acond ? m_uw.lit.jump.target : inc;
            CMD_CALL: begin
               nxt   = m_uw.lit.jump.target;
               m_ret = inc;
            end
            CMD_RET: begin
               nxt   = m_ret;
               n_ret = n_ret + 1;
            end
            CMD_LOOPLD: m_cnt = m_uw.lit.data[7:0];
            CMD_LOOP: begin
               if (m_cnt != 8'h00) begin
                  nxt    = m_uw.lit.jump.target;
                  m_cnt  = m_cnt - 8'd1;
                  n_loop = n_loop + 1;
               end
            end
            default: nxt = inc;
         endcase
      end
      m_csa = nxt;
      // Interrupt enables, vector turns ioni off
      if (vec || c == CMD_IOF) m_ioni = 1'b0;
      else if (c == CMD_ION) m_ioni = 1'b1;
      if (c == CMD_POF) m_poni = 1'b0;
      else if (c == CMD_PON) m_poni = 1'b1;
      m_level = highest_level(pend);
      m_intrq = (pend != '0) && !vec;
      // ALU flag and work register
      m_acond = m_uw.scond ? res[16] : (res[15:0] == 16'h0000);
      if (m_uw.idbs[0]) m_wreg = res[15:0];
      m_uw    = cs_word_t'(bits);
      m_etrap = !trap_in_n;
      m_lines = ln;
   end
   // Data bus register never reset
   m_cd = d;
endtask

`endif

// ==== dv/tb_cga_33.sv ====
// Gate array slice testbench
`default_nettype none

module tb_cga_33
   import cga_ucode_pkg::*;
   import cga_intr_pkg::*;
();

   logic        mclk;
   logic        rst;
   logic [63:0] csbits;
   logic [15:0] cd;
   logic        etrap_n;
   // Bit 0 is level 10 and bit 4 is level 15
   logic [4:0]  ibint_n;
   cs_addr_t    csa;
   logic [15:0] fidb;
   logic        acond;
   int_level_t  pil;
   logic        intrq_n;
   logic        ioni;
   logic        poni;
   logic        trap_n;
   logic [31:0] rng_state;

   `include "tb_cga_model.svh"

   cga_33 i_cga_33 (
      .mclk      (mclk),
      .rst       (rst),
      .csbits    (csbits),
      .cd        (cd),
      .etrap_n   (etrap_n),
      .ibint10_n (ibint_n[0]),
      .ibint11_n (ibint_n[1]),
      .ibint12_n (ibint_n[2]),
      .ibint13_n (ibint_n[3]),
      .ibint15_n (ibint_n[4]),
      .csa       (csa),
      .fidb      (fidb),
      .acond     (acond),
      .pil       (pil),
      .intrq_n   (intrq_n),
      .ioni      (ioni),
      .poni      (poni),
      .trap_n    (trap_n)
   );

   initial begin
      mclk = 1'b0;
      forever #50 mclk = ~mclk;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic compare_addr(input string name, input cs_addr_t got, input cs_addr_t exp);
      if (got !== exp) abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic compare_data(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
      if (got !== exp) abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic compare_level(input string name, input int_level_t got,
                                input int_level_t exp);
      if (got !== exp) abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Word with only a command and the vector bit
   function automatic logic [63:0] cmd_word(input logic [4:0] cmd, input logic vect);
      cs_word_t w;
      w      = '0;
      w.comm = cmd;
      w.vect = vect;
      return w;
   endfunction

   // Random word biased toward next and jump
   function automatic logic [63:0] random_word();
      logic [63:0] raw;
      logic [31:0] r;
      cs_word_t    w;
      raw[63:32] = next_rand();
      raw[31:0]  = next_rand();
      r          = next_rand();
      w          = cs_word_t'(raw);
      case (r[31:28])
         4'd8:    w.comm = CMD_CJUMP;
         4'd9:    w.comm = CMD_CALL;
         4'd10:   w.comm = CMD_RET;
         4'd11:   w.comm = CMD_LOOPLD;
         4'd12:   w.comm = CMD_LOOP;
         4'd13:   w.comm = CMD_ION;
         4'd14:   w.comm = r[20] ? CMD_IOF : (r[21] ? CMD_PON : CMD_POF);
         // Any code including undefined ones
         4'd15:   w.comm = r[8:4];
         default: w.comm = (r[31:28] < 4'd5) ? CMD_NEXT : CMD_JUMP;
      endcase
      w.vect = (r[11:10] == 2'b00);
      return w;
   endfunction

   task automatic check_outputs();
      compare_addr("csa", csa, m_csa);
      compare_data("fidb", fidb, m_fidb);
      compare_bit("acond", acond, m_acond);
      compare_level("pil", pil, m_pil);
      compare_bit("intrq_n", intrq_n, m_intrq_n);
      compare_bit("ioni", ioni, m_ioni_q);
      compare_bit("poni", poni, m_poni_q);
      compare_bit("trap_n", trap_n, m_trap_n);
   endtask

   // Model sees the sampled inputs before new ones go out
   task automatic cycle(input logic rst_in, input logic [63:0] word, input logic [15:0] data,
                        input logic trap_pin_n, input logic [4:0] int_pins_n);
      @(posedge mclk);
      model_step(rst, csbits, cd, etrap_n, int_lines_t'(~ibint_n));
      rst     <= rst_in;
      csbits  <= word;
      cd      <= data;
      etrap_n <= trap_pin_n;
      ibint_n <= int_pins_n;
      // Outputs settled mid-cycle
      @(negedge mclk);
      check_outputs();
   endtask

   task automatic random_cycle();
      logic [31:0] r;
      logic [31:0] s;
      logic [63:0] word;
      word = random_word();
      r    = next_rand();
      s    = next_rand();
      // Lines pending one time in four and traps about 1 in 32
      cycle(1'b0, word, r[31:16], r[15:11] != 5'd0, s[31:27] | s[26:22]);
   endtask

   task automatic wait_running();
      int t;
      t = 0;
      cycle(1'b0, cmd_word(CMD_NEXT, 1'b0), 16'h0000, 1'b1, 5'h1f);
      while (csa == RESET_ADDR) begin
         if (t == 10) begin
            abort_run("DUT stayed at the reset address after reset release");
         end else begin
            cycle(1'b0, cmd_word(CMD_NEXT, 1'b0), 16'h0000, 1'b1, 5'h1f);
            t = t + 1;
         end
      end
   endtask

   // All lines pending so level 15 wins
   task automatic wait_vector();
      int t;
      int start;
      t     = 0;
      start = n_vect;
      cycle(1'b0, cmd_word(CMD_ION, 1'b0), 16'h1234, 1'b1, 5'h00);
      while (n_vect == start) begin
         if (t == 20) begin
            abort_run("no vector taken with interrupts on and all lines pending");
         end else begin
            cycle(1'b0, cmd_word(CMD_NEXT, 1'b1), 16'h0000, 1'b1, 5'h00);
            t = t + 1;
         end
      end
      repeat (3) cycle(1'b0, cmd_word(CMD_NEXT, 1'b1), 16'h0000, 1'b1, 5'h00);
   endtask

   // Trap and one word at the trap address before the return
   task automatic trap_and_return();
      cycle(1'b0, cmd_word(CMD_NEXT, 1'b0), 16'h0000, 1'b0, 5'h1f);
      cycle(1'b0, cmd_word(CMD_NEXT, 1'b0), 16'h0000, 1'b1, 5'h1f);
      cycle(1'b0, cmd_word(CMD_RET, 1'b0), 16'h0000, 1'b1, 5'h1f);
      repeat (4) cycle(1'b0, cmd_word(CMD_NEXT, 1'b0), 16'h0000, 1'b1, 5'h1f);
   endtask

   initial begin
      rng_state = 32'h827e078b;
      n_trap    = 0;
      n_vect    = 0;
      n_ret     = 0;
      n_loop    = 0;
      rst       = 1'b1;
      csbits    = '0;
      cd        = 16'h0000;
      etrap_n   = 1'b1;
      ibint_n   = 5'h1f;
      // Reset seen on four edges
      repeat (3) cycle(1'b1, cmd_word(CMD_NEXT, 1'b0), 16'h0000, 1'b1, 5'h1f);
      wait_running();
      repeat (2000) random_cycle();
      wait_vector();
      trap_and_return();
      repeat (500) random_cycle();
      if (n_trap > 0 && n_vect > 0 && n_ret > 0 && n_loop > 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         abort_run("a trap, vector, return or taken loop was never exercised");
      end
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+dv
src/cga_ucode_pkg.sv
src/cga_intr_pkg.sv
src/cga_uword_in.sv
src/cga_alu.sv
src/cga_useq.sv
src/cga_int_level.sv
src/cga_out_stage.sv
src/cga_33.sv
dv/tb_cga_33.sv

// ==== src/cga_33.sv ====
// CPU gate array slice top
`default_nettype none

module cga_33
   import cga_ucode_pkg::*;
   import cga_intr_pkg::*;
(
   input  wire logic        mclk,
   input  wire logic        rst,
   input  wire logic [63:0] csbits,
   input  wire logic [15:0] cd,
   input  wire logic        etrap_n,
   input  wire logic        ibint10_n,
   input  wire logic        ibint11_n,
   input  wire logic        ibint12_n,
   input  wire logic        ibint13_n,
   input  wire logic        ibint15_n,
   output cs_addr_t         csa,
   output logic [15:0]      fidb,
   output logic             acond,
   output int_level_t       pil,
   output logic             intrq_n,
   output logic             ioni,
   output logic             poni,
   output logic             trap_n
);

   cs_word_t    uw;
   logic [15:0] cd_q;
   logic [15:0] alu_res;
   logic        etrap;
   logic        trap;
   logic        int_ack;
   int_lines_t  ibint;
   int_lines_t  lines;
   int_level_t  level;
   int_stat_t   stat;
   int_cmd_t    cmd;

   // Interrupt pins inverted to active high
   assign ibint.l10 = ~ibint10_n;
   assign ibint.l11 = ~ibint11_n;
   assign ibint.l12 = ~ibint12_n;
   assign ibint.l13 = ~ibint13_n;
   assign ibint.l15 = ~ibint15_n;

   cga_uword_in i_uword_in (
      .mclk    (mclk),
      .rst     (rst),
      .csbits  (csbits),
      .cd      (cd),
      .etrap_n (etrap_n),
      .ibint   (ibint),
      .uw      (uw),
      .cd_q    (cd_q),
      .etrap   (etrap),
      .lines   (lines)
   );

   cga_alu i_alu (
      .mclk    (mclk),
      .rst     (rst),
      .uw      (uw),
      .cd_q    (cd_q),
      .alu_res (alu_res),
      .acond   (acond)
   );

   cga_useq i_useq (
      .mclk    (mclk),
      .rst     (rst),
      .uw      (uw),
      .acond   (acond),
      .etrap   (etrap),
      .level   (level),
      .intrq   (stat.intrq),
      .csa     (csa),
      .trap    (trap),
      .cmd     (cmd),
      .int_ack (int_ack)
   );

   cga_int_level i_int_level (
      .mclk    (mclk),
      .rst     (rst),
      .lines   (lines),
      .cmd     (cmd),
      .int_ack (int_ack),
      .level   (level),
      .stat    (stat)
   );

   cga_out_stage i_out_stage (
      .mclk    (mclk),
      .rst     (rst),
      .alu_res (alu_res),
      .level   (level),
      .stat    (stat),
      .trap    (trap),
      .fidb    (fidb),
      .pil     (pil),
      .intrq_n (intrq_n),
      .ioni    (ioni),
      .poni    (poni),
      .trap_n  (trap_n)
   );

endmodule

`default_nettype wire

// ==== src/cga_alu.sv ====
// ALU and work register
`default_nettype none

module cga_alu
   import cga_ucode_pkg::*;
(
   input  wire logic        mclk,
   input  wire logic        rst,
   input  wire cs_word_t    uw,
   input  wire logic [15:0] cd_q,
   output logic [15:0]      alu_res,
   output logic             acond
);

   logic [15:0] wreg;
   logic [15:0] opb;
   logic [16:0] sum;
   logic        cin;
   logic        carry;
   alu_op_e     op;

   assign op  = alu_op_e'(uw.alui[2:0]);
   assign cin = uw.cinsel[0];

   // B is work register when rbsel[0] set, else literal
   assign opb = uw.rbsel[0] ? wreg : uw.lit.data;

   // Carry kept in bit 16
   always_comb begin
      case (op)
         OP_ADD:    sum = {1'b0, cd_q} + {1'b0, opb} + {16'h0000, cin};
         // Subtract as A plus not B, cin 1 for true difference
         OP_SUB:    sum = {1'b0, cd_q} + {1'b0, ~opb} + {16'h0000, cin};
         OP_AND:    sum = {1'b0, cd_q & opb};
         OP_OR:     sum = {1'b0, cd_q | opb};
         OP_XOR:    sum = {1'b0, cd_q ^ opb};
         OP_PASS_A: sum = {1'b0, cd_q};
         OP_PASS_B: sum = {1'b0, opb};
         default:   sum = {1'b0, cd_q} + 17'd1;
      endcase
   end

   assign alu_res = sum[15:0];
   assign carry   = sum[16];

   always_ff @(posedge mclk) begin
      if (rst) begin
         wreg  <= '0;
         acond <= 1'b0;
      end else begin
         // Write back on idbs bit 0
         if (uw.idbs[0]) begin
            wreg <= alu_res;
         end
         // scond picks carry, else zero
         acond <= uw.scond ? carry : (alu_res == 16'h0000);
      end
   end

endmodule

`default_nettype wire

// ==== src/cga_int_level.sv ====
// Interrupt level unit
`default_nettype none

module cga_int_level
   import cga_intr_pkg::*;
(
   input  wire logic       mclk,
   input  wire logic       rst,
   input  wire int_lines_t lines,
   input  wire int_cmd_t   cmd,
   input  wire logic       int_ack,
   output int_level_t      level,
   output int_stat_t       stat
);

   int_lines_t pend;
   int_level_t enc;

   // Lines count only while interrupts are on
   assign pend = stat.ioni ? lines : '0;

   // Highest pending level wins
   always_comb begin
      if (pend.l15) begin
         enc = 4'd15;
      end else if (pend.l13) begin
         enc = 4'd13;
      end else if (pend.l12) begin
         enc = 4'd12;
      end else if (pend.l11) begin
         enc = 4'd11;
      end else if (pend.l10) begin
         enc = 4'd10;
      end else begin
         enc = 4'd0;
      end
   end

   always_ff @(posedge mclk) begin
      if (rst) begin
         level <= 4'd0;
         stat  <= '0;
      end else begin
         // Vector taken turns interrupts off
         if (int_ack || cmd.iof) begin
            stat.ioni <= 1'b0;
         end else if (cmd.ion) begin
            stat.ioni <= 1'b1;
         end
         if (cmd.pof) begin
            stat.poni <= 1'b0;
         end else if (cmd.pon) begin
            stat.poni <= 1'b1;
         end
         level <= enc;
         // Dropped at once on ack so no second vector
         stat.intrq <= (pend != '0) && !int_ack;
      end
   end

endmodule

`default_nettype wire

// ==== src/cga_intr_pkg.sv ====
// Interrupt unit definitions
`default_nettype none

package cga_intr_pkg;

   // Pending lines, active high
   typedef struct packed {
      logic l15;
      logic l13;
      logic l12;
      logic l11;
      logic l10;
   } int_lines_t;

   typedef logic [3:0] int_level_t;

   typedef struct packed {
      logic ioni;
      logic poni;
      logic intrq;
   } int_stat_t;

   // One-cycle command pulses from the sequencer
   typedef struct packed {
      logic ion;
      logic iof;
      logic pon;
      logic pof;
   } int_cmd_t;

   // Trap entry and vector table
   localparam logic [12:0] TRAP_ADDR = 13'h1F00;
   localparam logic [12:0] VECT_BASE = 13'h1E00;

endpackage

`default_nettype wire

// ==== src/cga_out_stage.sv ====
// Output register stage
`default_nettype none

module cga_out_stage
   import cga_intr_pkg::*;
(
   input  wire logic        mclk,
   input  wire logic        rst,
   input  wire logic [15:0] alu_res,
   input  wire int_level_t  level,
   input  wire int_stat_t   stat,
   input  wire logic        trap,
   output logic [15:0]      fidb,
   output int_level_t       pil,
   output logic             intrq_n,
   output logic             ioni,
   output logic             poni,
   output logic             trap_n
);

   // Active-low pins idle high
   always_ff @(posedge mclk) begin
      if (rst) begin
         fidb    <= 16'h0000;
         pil     <= 4'd0;
         intrq_n <= 1'b1;
         ioni    <= 1'b0;
         poni    <= 1'b0;
         trap_n  <= 1'b1;
      end else begin
         fidb    <= alu_res;
         pil     <= level;
         intrq_n <= ~stat.intrq;
         ioni    <= stat.ioni;
         poni    <= stat.poni;
         // One-cycle low per trap
         trap_n  <= ~trap;
      end
   end

endmodule

`default_nettype wire

// ==== src/cga_ucode_pkg.sv ====
// Gate array microword definitions
`default_nettype none

package cga_ucode_pkg;

   // Control-store address
   typedef logic [12:0] cs_addr_t;

   localparam cs_addr_t RESET_ADDR = 13'h0000;

   // Literal seen by the sequencer
   typedef struct packed {
      logic [2:0] spare;
      cs_addr_t   target;
   } jump_t;

   // Same 16 bits, data constant for the ALU or branch target
   typedef union packed {
      logic [15:0] data;
      jump_t       jump;
   } cs_lit_u;

   // ALU operation, low bits of alui
   typedef enum logic [2:0] {
      OP_ADD    = 3'd0,
      OP_SUB    = 3'd1,
      OP_AND    = 3'd2,
      OP_OR     = 3'd3,
      OP_XOR    = 3'd4,
      OP_PASS_A = 3'd5,
      OP_PASS_B = 3'd6,
      OP_INC    = 3'd7
   } alu_op_e;

   // Sequencer command, unlisted codes behave as next
   typedef enum logic [4:0] {
      CMD_NEXT   = 5'd0,
      CMD_JUMP   = 5'd1,
      CMD_CJUMP  = 5'd2,
      CMD_CALL   = 5'd3,
      CMD_RET    = 5'd4,
      CMD_LOOPLD = 5'd5,
      CMD_LOOP   = 5'd6,
      CMD_ION    = 5'd7,
      CMD_IOF    = 5'd8,
      CMD_PON    = 5'd9,
      CMD_POF    = 5'd10
   } seq_cmd_e;

   // Full 64-bit microword, bit 63 first
   typedef struct packed {
      logic [8:0] alui;
      logic [1:0] sts;
      logic [1:0] rasel;
      logic       xref3;
      logic [1:0] rbsel;
      logic [1:0] cinsel;
      logic [1:0] alum;
      logic [1:0] mis;
      logic [4:0] idbs;
      logic [4:0] comm;
      logic [3:0] ts;
      // Used outside the gate array
      logic [1:0] delay;
      logic       vect;
      logic       scond;
      logic       econd;
      logic       loop;
      logic       dly;
      logic       bit20;
      logic [3:0] rb;
      cs_lit_u    lit;
   } cs_word_t;

endpackage

`default_nettype wire

// ==== src/cga_useq.sv ====
// Microsequencer
`default_nettype none

module cga_useq
   import cga_ucode_pkg::*;
   import cga_intr_pkg::*;
(
   input  wire logic       mclk,
   input  wire logic       rst,
   input  wire cs_word_t   uw,
   input  wire logic       acond,
   input  wire logic       etrap,
   input  wire int_level_t level,
   input  wire logic       intrq,
   output cs_addr_t        csa,
   output logic            trap,
   output int_cmd_t        cmd,
   output logic            int_ack
);

   cs_addr_t   csa_inc;
   cs_addr_t   csa_d;
   cs_addr_t   target;
   cs_addr_t   ret_q;
   logic [7:0] loop_cnt;
   logic       take_vect;
   logic       take_comm;
   logic       loop_run;
   seq_cmd_e   op;

   assign csa_inc = csa + 13'd1;
   assign target  = uw.lit.jump.target;
   assign op      = seq_cmd_e'(uw.comm);

   // Trap beats vector, vector beats command
   assign take_vect = !etrap && uw.vect && intrq;
   assign take_comm = !etrap && !take_vect;
   assign loop_run  = (loop_cnt != 8'h00);

   assign trap    = etrap;
   assign int_ack = take_vect;

   // Interrupt commands only when the command field is decoded
   always_comb begin
      cmd     = '0;
      cmd.ion = take_comm && (op == CMD_ION);
      cmd.iof = take_comm && (op == CMD_IOF);
      cmd.pon = take_comm && (op == CMD_PON);
      cmd.pof = take_comm && (op == CMD_POF);
   end

   // Next address select
   always_comb begin
      csa_d = csa_inc;
      if (etrap) begin
         csa_d = TRAP_ADDR;
      end else if (take_vect) begin
         // Four words per level
         csa_d = VECT_BASE + {7'b0, level, 2'b00};
      end else begin
         case (op)
            CMD_JUMP,
            CMD_CALL: csa_d = target;
            CMD_CJUMP: begin
               if (acond) begin
                  csa_d = target;
               end
            end
            CMD_RET:  csa_d = ret_q;
            CMD_LOOP: begin
               if (loop_run) begin
                  csa_d = target;
               end
            end
            default:  csa_d = csa_inc;
         endcase
      end
   end

   always_ff @(posedge mclk) begin
      if (rst) begin
         csa      <= RESET_ADDR;
         ret_q    <= RESET_ADDR;
         loop_cnt <= 8'h00;
      end else begin
         csa <= csa_d;
         // Return point for trap and call
         if (etrap || (take_comm && op == CMD_CALL)) begin
            ret_q <= csa_inc;
         end
         // Loop counter from literal low byte
         if (take_comm && op == CMD_LOOPLD) begin
            loop_cnt <= uw.lit.data[7:0];
         end else if (take_comm && op == CMD_LOOP && loop_run) begin
            loop_cnt <= loop_cnt - 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/cga_uword_in.sv ====
// Input register stage
`default_nettype none

module cga_uword_in
   import cga_ucode_pkg::*;
   import cga_intr_pkg::*;
(
   input  wire logic        mclk,
   input  wire logic        rst,
   input  wire logic [63:0] csbits,
   input  wire logic [15:0] cd,
   input  wire logic        etrap_n,
   input  wire int_lines_t  ibint,
   output cs_word_t         uw,
   output logic [15:0]      cd_q,
   output logic             etrap,
   output int_lines_t       lines
);

   // Control side, cleared word decodes as next with no vector
   always_ff @(posedge mclk) begin
      if (rst) begin
         uw    <= '0;
         etrap <= 1'b0;
         lines <= '0;
      end else begin
         uw    <= cs_word_t'(csbits);
         // Trap made active high here
         etrap <= ~etrap_n;
         lines <= ibint;
      end
   end

   // Data bus operand
   always_ff @(posedge mclk) begin
      cd_q <= cd;
   end

endmodule

`default_nettype wire
